/* include/udp_tx_settings.svh */
// Width and size constants for the UDP transmitter, included by the package and the RTL
`ifndef UDP_TX_SETTINGS_SVH
`define UDP_TX_SETTINGS_SVH

// payload stream byte width
`define UDP_TX_BYTE_W 8

// length fields and byte pointer
`define UDP_TX_LEN_W 16

// bytes in the UDP header that lead the payload
`define UDP_TX_UDP_HDR_BYTES 8

// bytes added to the UDP length to form the IP length
`define UDP_TX_IP_HDR_BYTES 20

`endif

/* logic/udp_tx_pkg.sv */
// Shared header, payload beat and state types for the UDP transmitter; import where needed
`default_nettype none

`include "udp_tx_settings.svh"

package udp_tx_pkg;

    // IP header fields, most significant field first
    typedef struct packed {
        logic [3:0]               version;
        logic [3:0]               ihl;
        logic [5:0]               dscp;
        logic [1:0]               ecn;
        logic [`UDP_TX_LEN_W-1:0] length;
        logic [15:0]              identification;
        logic [2:0]               flags;
        logic [12:0]              fragment_offset;
        logic [7:0]               ttl;
        logic [7:0]               protocol;
        logic [15:0]              header_checksum;
        logic [31:0]              source_ip;
        logic [31:0]              dest_ip;
    } ip_hdr_t;

    // UDP header in wire order
    typedef struct packed {
        logic [15:0]              source_port;
        logic [15:0]              dest_port;
        logic [`UDP_TX_LEN_W-1:0] length;
        logic [15:0]              checksum;
    } udp_hdr_t;

    // input header word; ip.length is ignored
    typedef struct packed {
        ip_hdr_t  ip;
        udp_hdr_t udp;
    } udp_tx_hdr_t;

    // one payload beat
    typedef struct packed {
        logic [`UDP_TX_BYTE_W-1:0] data;
        logic                      last;
        logic                      user;
    } axis_byte_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_HEADER,
        TX_PAYLOAD,
        TX_PAYLOAD_LAST
    } tx_state_e;

endpackage

`default_nettype wire

/* logic/udp_ip_hdr_reg.sv */
// Holds an accepted UDP header and presents the derived IP header until downstream takes it
`timescale 1ns/10ps
`default_nettype none

`include "udp_tx_settings.svh"

module udp_ip_hdr_reg (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  hdr_take,
    input  udp_tx_pkg::udp_tx_hdr_t s_hdr,
    output udp_tx_pkg::udp_hdr_t  udp_hdr,
    output udp_tx_pkg::ip_hdr_t   m_ip_hdr,
    output logic                  m_ip_hdr_valid,
    input  logic                  m_ip_hdr_ready,
    output logic                  ip_hdr_pending
);

    // valid flag, set on capture and cleared once taken
    always_ff @(posedge clk) begin
        if (rst) begin
            m_ip_hdr_valid <= 1'b0;
        end else if (hdr_take) begin
            m_ip_hdr_valid <= 1'b1;
        end else if (m_ip_hdr_ready) begin
            m_ip_hdr_valid <= 1'b0;
        end
    end

    // header payload registers
    always_ff @(posedge clk) begin
        if (hdr_take) begin
            m_ip_hdr        <= s_hdr.ip;
            // IP length covers the UDP datagram plus the IP header
            m_ip_hdr.length <= s_hdr.udp.length + `UDP_TX_LEN_W'(`UDP_TX_IP_HDR_BYTES);
            udp_hdr         <= s_hdr.udp;
        end
    end

    assign ip_hdr_pending = m_ip_hdr_valid;

    // framer must not start a new frame over an untaken IP header
    a_no_take_while_pending: assert property (
        @(posedge clk) disable iff (rst)
        hdr_take |-> !ip_hdr_pending
    ) else $error("header captured while previous IP header still pending");

endmodule

`default_nettype wire

/* logic/udp_tx_framer.sv */
// Serializes the UDP header ahead of the payload and holds the stream to the UDP length
`timescale 1ns/10ps
`default_nettype none

`include "udp_tx_settings.svh"

module udp_tx_framer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   s_hdr_valid,
    output logic                   s_hdr_ready,
    output logic                   hdr_take,
    input  udp_tx_pkg::udp_hdr_t   udp_hdr,
    input  logic                   ip_hdr_pending,
    input  udp_tx_pkg::axis_byte_t s_payload,
    input  logic                   s_payload_valid,
    output logic                   s_payload_ready,
    output udp_tx_pkg::axis_byte_t beat,
    output logic                   beat_valid,
    input  logic                   beat_ready,
    output logic                   error_early_term
);

    import udp_tx_pkg::*;

    localparam int HDR_BITS = `UDP_TX_UDP_HDR_BYTES * `UDP_TX_BYTE_W;

    tx_state_e                 state;
    tx_state_e                 state_next;
    logic [`UDP_TX_LEN_W-1:0]  ptr;
    logic [`UDP_TX_LEN_W-1:0]  ptr_next;
    logic [`UDP_TX_LEN_W-1:0]  ptr_inc;
    logic                      len_hit;
    logic                      store_last;
    logic                      error_next;
    logic [`UDP_TX_BYTE_W-1:0] last_data;
    logic [HDR_BITS-1:0]       hdr_bits;
    logic [`UDP_TX_BYTE_W-1:0] hdr_byte;

    assign hdr_take = s_hdr_valid && s_hdr_ready;

    // header bytes go out most significant first
    assign hdr_bits = udp_hdr;
    assign hdr_byte = hdr_bits[`UDP_TX_BYTE_W * (`UDP_TX_UDP_HDR_BYTES - 1 - ptr[2:0])
                               +: `UDP_TX_BYTE_W];

    // ptr counts bytes of the UDP datagram sent so far
    assign ptr_inc = ptr + 1'b1;
    assign len_hit = ptr_inc == udp_hdr.length;

    always_comb begin
        state_next      = state;
        ptr_next        = ptr;
        store_last      = 1'b0;
        error_next      = 1'b0;
        beat            = '0;
        beat_valid      = 1'b0;
        s_payload_ready = 1'b0;

        case (state)
            TX_IDLE: begin
                if (hdr_take) begin
                    ptr_next   = '0;
                    state_next = TX_HEADER;
                end
            end
            TX_HEADER: begin
                beat.data  = hdr_byte;
                beat_valid = 1'b1;
                if (beat_ready) begin
                    ptr_next = ptr_inc;
                    if (ptr == `UDP_TX_LEN_W'(`UDP_TX_UDP_HDR_BYTES - 1)) begin
                        state_next = TX_PAYLOAD;
                    end
                end
            end
            TX_PAYLOAD: begin
                s_payload_ready = beat_ready;
                beat            = s_payload;
                // hold back the byte that reaches the length before last
                beat_valid      = s_payload_valid && (s_payload.last || !len_hit);
                if (s_payload.last && !len_hit) begin
                    beat.user = 1'b1;
                end
                if (s_payload_valid && beat_ready) begin
                    ptr_next = ptr_inc;
                    if (s_payload.last) begin
                        error_next = !len_hit;
                        state_next = TX_IDLE;
                    end else if (len_hit) begin
                        store_last = 1'b1;
                        state_next = TX_PAYLOAD_LAST;
                    end
                end
            end
            TX_PAYLOAD_LAST: begin
                // drop excess input, release the kept byte with the input's last
                s_payload_ready = beat_ready;
                beat.data       = last_data;
                beat.last       = 1'b1;
                beat.user       = s_payload.user;
                beat_valid      = s_payload_valid && s_payload.last;
                if (s_payload_valid && beat_ready && s_payload.last) begin
                    state_next = TX_IDLE;
                end
            end
            default: begin
                state_next = TX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= TX_IDLE;
            ptr              <= '0;
            s_hdr_ready      <= 1'b0;
            error_early_term <= 1'b0;
        end else begin
            state            <= state_next;
            ptr              <= ptr_next;
            // wait for the previous IP header to be taken
            s_hdr_ready      <= (state_next == TX_IDLE) && !ip_hdr_pending;
            error_early_term <= error_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_last) begin
            last_data <= s_payload.data;
        end
    end

    // a stalled beat holds until the skid buffer takes it
    a_beat_hold: assert property (
        @(posedge clk) disable iff (rst)
        beat_valid && !beat_ready |=> beat_valid && $stable(beat)
    ) else $error("beat changed while stalled");

endmodule

`default_nettype wire

/* logic/axis_skid_buffer.sv */
// Two-entry output stage for the payload stream; ready toward the source comes from a flop
`timescale 1ns/10ps
`default_nettype none

module axis_skid_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  udp_tx_pkg::axis_byte_t s_beat,
    input  logic                   s_valid,
    output logic                   s_ready,
    output udp_tx_pkg::axis_byte_t m_beat,
    output logic                   m_valid,
    input  logic                   m_ready
);

    import udp_tx_pkg::*;

    axis_byte_t temp_beat;
    logic       temp_valid;
    logic       temp_valid_next;
    logic       m_valid_next;
    logic       in_xfer;
    logic       out_free;

    assign in_xfer  = s_valid && s_ready;
    assign out_free = m_ready || !m_valid;

    always_comb begin
        m_valid_next    = m_valid;
        temp_valid_next = temp_valid;
        if (in_xfer) begin
            if (out_free) begin
                m_valid_next = 1'b1;
            end else begin
                temp_valid_next = 1'b1;
            end
        end else if (out_free) begin
            // temp entry drains into the output
            m_valid_next    = temp_valid;
            temp_valid_next = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid    <= 1'b0;
            temp_valid <= 1'b0;
            s_ready    <= 1'b0;
        end else begin
            m_valid    <= m_valid_next;
            temp_valid <= temp_valid_next;
            // only a full temp entry blocks the source
            s_ready    <= !temp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer && out_free) begin
            m_beat <= s_beat;
        end else if (!in_xfer && out_free && temp_valid) begin
            m_beat <= temp_beat;
        end
        if (in_xfer && !out_free) begin
            temp_beat <= s_beat;
        end
    end

    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (rst)
        m_valid && !m_ready |=> m_valid && $stable(m_beat)
    ) else $error("output beat changed while stalled");

endmodule

`default_nettype wire

/* logic/udp_ip_tx.sv */
// Top level of the UDP to IP transmitter: header register, framer and output skid buffer
`timescale 1ns/10ps
`default_nettype none

module udp_ip_tx (
    input  logic                    clk,
    input  logic                    rst,
    input  udp_tx_pkg::udp_tx_hdr_t s_hdr,
    input  logic                    s_hdr_valid,
    output logic                    s_hdr_ready,
    input  udp_tx_pkg::axis_byte_t  s_payload,
    input  logic                    s_payload_valid,
    output logic                    s_payload_ready,
    output udp_tx_pkg::ip_hdr_t     m_ip_hdr,
    output logic                    m_ip_hdr_valid,
    input  logic                    m_ip_hdr_ready,
    output udp_tx_pkg::axis_byte_t  m_payload,
    output logic                    m_payload_valid,
    input  logic                    m_payload_ready,
    output logic                    error_early_term
);

    import udp_tx_pkg::*;

    logic       hdr_take;
    logic       ip_hdr_pending;
    udp_hdr_t   udp_hdr;
    axis_byte_t beat;
    logic       beat_valid;
    logic       beat_ready;

    udp_ip_hdr_reg u_hdr_reg (
        .clk            (clk),
        .rst            (rst),
        .hdr_take       (hdr_take),
        .s_hdr          (s_hdr),
        .udp_hdr        (udp_hdr),
        .m_ip_hdr       (m_ip_hdr),
        .m_ip_hdr_valid (m_ip_hdr_valid),
        .m_ip_hdr_ready (m_ip_hdr_ready),
        .ip_hdr_pending (ip_hdr_pending)
    );

    udp_tx_framer u_framer (
        .clk              (clk),
        .rst              (rst),
        .s_hdr_valid      (s_hdr_valid),
        .s_hdr_ready      (s_hdr_ready),
        .hdr_take         (hdr_take),
        .udp_hdr          (udp_hdr),
        .ip_hdr_pending   (ip_hdr_pending),
        .s_payload        (s_payload),
        .s_payload_valid  (s_payload_valid),
        .s_payload_ready  (s_payload_ready),
        .beat             (beat),
        .beat_valid       (beat_valid),
        .beat_ready       (beat_ready),
        .error_early_term (error_early_term)
    );

    axis_skid_buffer u_skid (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (beat),
        .s_valid (beat_valid),
        .s_ready (beat_ready),
        .m_beat  (m_payload),
        .m_valid (m_payload_valid),
        .m_ready (m_payload_ready)
    );

endmodule

`default_nettype wire

/* dv/tb_udp_ip_tx.sv */
// Self-checking testbench for udp_ip_tx; run as top module tb_udp_ip_tx with compile.f
`timescale 1ns/10ps
`default_nettype none

`include "udp_tx_settings.svh"

module tb_udp_ip_tx;

    import udp_tx_pkg::*;

    localparam int          NUM_FRAMES = 36;
    localparam logic [31:0] SEED       = 32'hd2cb744a;

    logic        clk             = 1'b0;
    logic        rst             = 1'b1;
    udp_tx_hdr_t s_hdr           = '0;
    logic        s_hdr_valid     = 1'b0;
    logic        s_hdr_ready;
    axis_byte_t  s_payload       = '0;
    logic        s_payload_valid = 1'b0;
    logic        s_payload_ready;
    ip_hdr_t     m_ip_hdr;
    logic        m_ip_hdr_valid;
    logic        m_ip_hdr_ready  = 1'b0;
    axis_byte_t  m_payload;
    logic        m_payload_valid;
    logic        m_payload_ready = 1'b0;
    logic        error_early_term;

    logic [31:0] stim_state = SEED;
    // ready patterns run from their own generator state
    logic [31:0] rdy_state  = SEED ^ 32'h9e3779b9;
    logic        gen_done   = 1'b0;
    logic        last_seen  = 1'b0;
    int          total_out  = 0;
    int          hdrs_checked  = 0;
    int          beats_checked = 0;
    int          errs_checked  = 0;

    udp_tx_hdr_t hdr_stim_q[$];
    int          count_stim_q[$];
    axis_byte_t  beat_stim_q[$];
    ip_hdr_t     exp_hdr_q[$];
    axis_byte_t  exp_beat_q[$];
    logic        exp_err_q[$];
    ip_hdr_t     obs_hdr_q[$];
    axis_byte_t  obs_beat_q[$];
    logic        obs_err_q[$];

    udp_ip_tx u_udp_ip_tx (
        .clk              (clk),
        .rst              (rst),
        .s_hdr            (s_hdr),
        .s_hdr_valid      (s_hdr_valid),
        .s_hdr_ready      (s_hdr_ready),
        .s_payload        (s_payload),
        .s_payload_valid  (s_payload_valid),
        .s_payload_ready  (s_payload_ready),
        .m_ip_hdr         (m_ip_hdr),
        .m_ip_hdr_valid   (m_ip_hdr_valid),
        .m_ip_hdr_ready   (m_ip_hdr_ready),
        .m_payload        (m_payload),
        .m_payload_valid  (m_payload_valid),
        .m_payload_ready  (m_payload_ready),
        .error_early_term (error_early_term)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function logic [31:0] next_stim();
        stim_state = lcg_step(stim_state);
        return stim_state;
    endfunction

    // upper LCG bits, reduced to 0 .. n-1
    function int unsigned pick(input int unsigned n);
        logic [31:0] r;
        r = next_stim();
        return int'(r[31:16]) % n;
    endfunction

    task automatic end_in_failure();
        $display("Some tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_ip_hdr(input ip_hdr_t exp, input ip_hdr_t got);
        if (got !== exp) begin
            $display("FAILED at %0t: m_ip_hdr expected %h got %h", $time, exp, got);
            end_in_failure();
        end
    endtask

    task automatic check_beat(input axis_byte_t exp, input axis_byte_t got);
        if (got !== exp) begin
            $display("FAILED at %0t: m_payload expected %h got %h", $time, exp, got);
            end_in_failure();
        end
    endtask

    task automatic check_error(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("FAILED at %0t: %s expected %b got %b", $time, name, exp, got);
            end_in_failure();
        end
    endtask

    // expected IP header, output bytes and error flag of one frame
    function automatic void model_frame(input udp_tx_hdr_t h, input axis_byte_t in_beats[$]);
        ip_hdr_t    eh;
        logic [63:0] hdr64;
        axis_byte_t b;
        int         n_keep;
        int         n_in;
        int         n_out;
        eh        = h.ip;
        eh.length = h.udp.length + 16'(`UDP_TX_IP_HDR_BYTES);
        exp_hdr_q.push_back(eh);
        hdr64 = h.udp;
        for (int i = 0; i < `UDP_TX_UDP_HDR_BYTES; i++) begin
            b      = '0;
            b.data = hdr64[63 - 8 * i -: 8];
            exp_beat_q.push_back(b);
        end
        n_keep = int'(h.udp.length) - `UDP_TX_UDP_HDR_BYTES;
        n_in   = in_beats.size();
        n_out  = (n_in < n_keep) ? n_in : n_keep;
        for (int i = 0; i < n_out; i++) begin
            b      = in_beats[i];
            b.last = (i == n_out - 1);
            if (i == n_out - 1) begin
                // short frames flag the final byte, otherwise user comes from input last
                b.user = (n_in < n_keep) ? 1'b1 : in_beats[n_in - 1].user;
            end
            exp_beat_q.push_back(b);
        end
        exp_err_q.push_back(n_in < n_keep);
        total_out += `UDP_TX_UDP_HDR_BYTES + n_out;
    endfunction

    task automatic send_header(input udp_tx_hdr_t h);
        repeat (pick(3)) @(posedge clk);
        s_hdr       <= h;
        s_hdr_valid <= 1'b1;
        @(posedge clk);
        while (!s_hdr_ready) @(posedge clk);
        s_hdr_valid <= 1'b0;
    endtask

    task automatic send_beat(input axis_byte_t b);
        int unsigned gap;
        gap = (pick(4) == 0) ? 1 + pick(3) : 0;
        if (gap != 0) begin
            s_payload_valid <= 1'b0;
            repeat (gap) @(posedge clk);
        end
        s_payload       <= b;
        s_payload_valid <= 1'b1;
        @(posedge clk);
        while (!s_payload_ready) @(posedge clk);
    endtask

    // random back-pressure on both outputs
    always @(posedge clk) begin
        rdy_state = lcg_step(rdy_state);
        m_payload_ready <= rdy_state[31:30] != 2'd0;
        m_ip_hdr_ready  <= rdy_state[29:27] > 3'd2;
    end

    always @(posedge clk) begin
        if (!rst && m_ip_hdr_valid && m_ip_hdr_ready) begin
            obs_hdr_q.push_back(m_ip_hdr);
        end
        if (!rst && m_payload_valid && m_payload_ready) begin
            obs_beat_q.push_back(m_payload);
        end
    end

    // error pulse is sampled one cycle after an input last is accepted
    always @(posedge clk) begin
        if (!rst) begin
            if (last_seen) begin
                obs_err_q.push_back(error_early_term);
            end else if (error_early_term) begin
                $display("error_early_term pulsed at %0t without a preceding last byte", $time);
                end_in_failure();
            end
            last_seen <= s_payload_valid && s_payload_ready && s_payload.last;
        end
    end

    always @(negedge clk) begin
        while (obs_hdr_q.size() != 0) begin
            if (exp_hdr_q.size() == 0) begin
                $display("an IP header came out that no frame accounts for");
                end_in_failure();
            end else begin
                check_ip_hdr(exp_hdr_q.pop_front(), obs_hdr_q.pop_front());
                hdrs_checked = hdrs_checked + 1;
            end
        end
        while (obs_beat_q.size() != 0) begin
            if (exp_beat_q.size() == 0) begin
                $display("a payload byte came out beyond the expected stream");
                end_in_failure();
            end else begin
                check_beat(exp_beat_q.pop_front(), obs_beat_q.pop_front());
                beats_checked = beats_checked + 1;
            end
        end
        while (obs_err_q.size() != 0) begin
            check_error("error_early_term", exp_err_q.pop_front(), obs_err_q.pop_front());
            errs_checked = errs_checked + 1;
        end
    end

    initial begin : watchdog
        wait (gen_done);
        repeat (64 * total_out + 1000) @(posedge clk);
        $display("timeout: frames did not finish within %0d cycles", 64 * total_out + 1000);
        end_in_failure();
    end

    initial begin : main
        udp_tx_hdr_t h;
        logic [223:0] raw;
        axis_byte_t   b;
        axis_byte_t   in_beats[$];
        int           n_keep;
        int           n_in;
        // kinds rotate exact, short, long
        for (int f = 0; f < NUM_FRAMES; f++) begin
            raw = '0;
            for (int k = 0; k < 7; k++) begin
                raw = {raw[191:0], next_stim()};
            end
            h      = raw;
            n_keep = 2 + int'(pick(23));
            case (f % 3)
                0:       n_in = n_keep;
                1:       n_in = 1 + int'(pick(n_keep - 1));
                default: n_in = n_keep + 1 + int'(pick(6));
            endcase
            h.udp.length = 16'(`UDP_TX_UDP_HDR_BYTES + n_keep);
            in_beats.delete();
            for (int i = 0; i < n_in; i++) begin
                b.data = 8'(pick(256));
                b.last = (i == n_in - 1);
                b.user = (i == n_in - 1) ? 1'(pick(2)) : 1'b0;
                in_beats.push_back(b);
                beat_stim_q.push_back(b);
            end
            hdr_stim_q.push_back(h);
            count_stim_q.push_back(n_in);
            model_frame(h, in_beats);
        end
        gen_done = 1'b1;

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_error("s_hdr_ready", 1'b0, s_hdr_ready);
        check_error("s_payload_ready", 1'b0, s_payload_ready);
        check_error("m_ip_hdr_valid", 1'b0, m_ip_hdr_valid);
        check_error("m_payload_valid", 1'b0, m_payload_valid);
        check_error("error_early_term", 1'b0, error_early_term);
        @(posedge clk);
        check_error("s_hdr_ready", 1'b1, s_hdr_ready);

        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_header(hdr_stim_q[f]);
            repeat (count_stim_q[f]) begin
                send_beat(beat_stim_q.pop_front());
            end
            s_payload_valid <= 1'b0;
        end

        wait (hdrs_checked == NUM_FRAMES && beats_checked == total_out
              && errs_checked == NUM_FRAMES);
        // idle tail to catch stray bytes or pulses
        repeat (50) @(posedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
logic/udp_tx_pkg.sv
logic/udp_ip_hdr_reg.sv
logic/udp_tx_framer.sv
logic/axis_skid_buffer.sv
logic/udp_ip_tx.sv
dv/tb_udp_ip_tx.sv

/* Bender.yml */
package:
  name: udp_ip_tx

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/udp_tx_pkg.sv
      - logic/udp_ip_hdr_reg.sv
      - logic/udp_tx_framer.sv
      - logic/axis_skid_buffer.sv
      - logic/udp_ip_tx.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_udp_ip_tx.sv
